/* Bender.yml */
package:
  name: cpu

sources:
  # packages first, then the blocks and the top
  - verilog/cpu_types_pkg.sv
  - verilog/cpu_ctrl_pkg.sv
  - verilog/control_unit.sv
  - verilog/imm_decode.sv
  - verilog/register_file.sv
  - verilog/alu.sv
  - verilog/pc_unit.sv
  - verilog/cpu.sv
  - target: test
    files:
      - testbench/cpu_asserts.sv
      - testbench/cpu_tb.sv

/* testbench/cpu_asserts.sv */
/*
 * bound checker for the cpu top
 *   pc word alignment and reset value
 *   no commit during reset, x0 reads as zero
 */
module cpu_asserts (
    input logic                     clk,
    input logic                     rst,
    input cpu_types_pkg::word_t     pc,
    input cpu_types_pkg::commit_t   commit,
    input cpu_types_pkg::reg_addr_t rs1_addr,
    input cpu_types_pkg::reg_addr_t rs2_addr,
    input cpu_types_pkg::word_t     src1,
    input cpu_types_pkg::word_t     src2
);
    import cpu_types_pkg::*;

    // failure count, summed into the testbench totals
    int failures = 0;

    // jalr clears bit 0 only, bit 1 has to be clear already
    pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else begin
            failures++;
            $error("pc %h is not word aligned", pc);
        end

    pc_reset: assert property (@(posedge clk) rst |=> pc == RESET_PC)
        else begin
            failures++;
            $error("pc %h after a reset edge", pc);
        end

    no_commit_in_reset: assert property (@(posedge clk) rst |-> !commit.en)
        else begin
            failures++;
            $error("commit.en high during reset");
        end

    // both read ports
    x0_read_a: assert property (@(posedge clk) (rs1_addr == '0) |-> (src1 == '0))
        else begin
            failures++;
            $error("x0 read on port a gave %h", src1);
        end

    x0_read_b: assert property (@(posedge clk) (rs2_addr == '0) |-> (src2 == '0))
        else begin
            failures++;
            $error("x0 read on port b gave %h", src2);
        end

endmodule

/* testbench/cpu_tb.sv */
/*
 * testbench for the single-cycle rv32i core
 *   clock and reset, x0-write filler during reset
 *   instruction feed and expected values from the vectors file
 *   typed compare tasks, per-group report, bound checker hookup
 */
module cpu_tb;
    import cpu_types_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_LINES    = 200;
    // outputs are sampled this long after the falling edge
    localparam int SETTLE       = 2;

    logic    clk = 1'b0;
    logic    rst;
    word_t   cmd;
    word_t   pc;
    word_t   dnpc;
    commit_t commit;

    integer      seed;
    integer      fd;
    integer      lines;
    integer      fields;
    integer      grp;
    integer      cur_grp;
    integer      total_checks;
    integer      total_errors;
    integer      grp_checks;
    integer      grp_errors;
    string       line;
    word_t       inst;
    word_t       exp_pc;
    word_t       exp_dnpc;
    word_t       exp_data;
    logic [31:0] exp_en;
    logic [31:0] exp_rd;
    commit_t     exp_commit;

    cpu dut0 (
        .clk    (clk),
        .rst    (rst),
        .cmd    (cmd),
        .pc     (pc),
        .dnpc   (dnpc),
        .commit (commit)
    );

    // checker sees internal read ports of the top
    bind cpu cpu_asserts asrt0 (
        .clk      (clk),
        .rst      (rst),
        .pc       (pc),
        .commit   (commit),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .src1     (src1),
        .src2     (src2)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // add to x0 with a random rs2, wb_en set but nothing is stored
    function automatic word_t filler_insn();
        reg_addr_t rs2;
        rs2 = reg_addr_t'($random(seed));
        filler_insn = {7'b0, rs2, 5'd0, 3'b000, 5'd0, 7'b0110011};
    endfunction

    function automatic string group_name(input integer g);
        case (g)
            1:       group_name = "reset";
            2:       group_name = "arithmetic";
            3:       group_name = "x0";
            4:       group_name = "branches";
            5:       group_name = "jumps";
            6:       group_name = "unsupported";
            default: group_name = "unknown";
        endcase
    endfunction

    task automatic tally(input logic ok);
        total_checks++;
        grp_checks++;
        if (!ok) begin
            total_errors++;
            grp_errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
        tally(got === exp);
    endtask

    // rd and data only matter when a write is expected
    task automatic check_commit(input commit_t got, input commit_t exp);
        logic ok;
        ok = (got.en === exp.en);
        if (!ok)
            $display("error at %0t: commit.en = %b, expected %b", $time, got.en, exp.en);
        if (exp.en) begin
            if (got.rd !== exp.rd) begin
                $display("error at %0t: commit.rd = %0d, expected %0d",
                         $time, got.rd, exp.rd);
                ok = 1'b0;
            end
            if (got.data !== exp.data) begin
                $display("error at %0t: commit.data = %h, expected %h",
                         $time, got.data, exp.data);
                ok = 1'b0;
            end
        end
        tally(ok);
    endtask

    task automatic report_group(input integer g);
        $display("test %-12s %0d checks, %0d errors: %s", group_name(g),
                 grp_checks, grp_errors, (grp_errors == 0) ? "ok" : "bad");
        grp_checks = 0;
        grp_errors = 0;
    endtask

    initial begin
        seed         = 87;
        total_checks = 0;
        total_errors = 0;
        grp_checks   = 0;
        grp_errors   = 0;
        cur_grp      = 1;
        rst          = 1'b1;
        cmd          = filler_insn();

        // pc pinned to reset value, nothing retires
        // rst falls at the eighth falling edge, with the first vector
        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            @(negedge clk);
            cmd = filler_insn();
            #SETTLE;
            check_word("pc", pc, RESET_PC);
            check_commit(commit, '{en: 1'b0, rd: '0, data: '0});
        end

        fd = $fopen("testbench/cpu_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/cpu_vectors.txt");
            total_errors++;
        end else begin
            lines = 0;
            // bounded read, one cycle per vector line
            while (!$feof(fd) && lines < MAX_LINES) begin
                line = "";
                void'($fgets(line, fd));
                lines++;
                fields = $sscanf(line, "%d %h %h %h %h %h %h", grp, inst,
                                 exp_pc, exp_dnpc, exp_en, exp_rd, exp_data);
                // comment and blank lines fall through
                if (fields == 7) begin
                    if (grp != cur_grp) begin
                        report_group(cur_grp);
                        cur_grp = grp;
                    end
                    @(negedge clk);
                    rst = 1'b0;
                    cmd = inst;
                    #SETTLE;
                    exp_commit = '{en: exp_en[0], rd: exp_rd[4:0], data: exp_data};
                    check_word("pc", pc, exp_pc);
                    check_word("dnpc", dnpc, exp_dnpc);
                    check_commit(commit, exp_commit);
                end
            end
            report_group(cur_grp);
            if (!$feof(fd)) begin
                $display("the vector file did not end within %0d lines", MAX_LINES);
                total_errors++;
            end
            $fclose(fd);
        end

        // assertions of the last vector cycle fire at its closing edge
        @(negedge clk);
        if (dut0.asrt0.failures != 0) begin
            $display("%0d assertion failures in the bound checker", dut0.asrt0.failures);
            total_errors += dut0.asrt0.failures;
        end

        $display("%0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* testbench/cpu_vectors.txt */
# group(dec) insn pc dnpc commit_en commit_rd commit_data (hex)
# groups: 2 arithmetic, 3 x0, 4 branches, 5 jumps, 6 unsupported opcodes
2 00500093 00000000 00000004 1 01 00000005
2 ffd00113 00000004 00000008 1 02 fffffffd
2 123451b7 00000008 0000000c 1 03 12345000
2 00208233 0000000c 00000010 1 04 00000002
2 402082b3 00000010 00000014 1 05 00000008
2 40115333 00000014 00000018 1 06 ffffffff
2 001123b3 00000018 0000001c 1 07 00000001
2 00113433 0000001c 00000020 1 08 00000000
2 0021c4b3 00000020 00000024 1 09 edcbaffd
2 40115513 00000024 00000028 1 0a fffffffe
3 00700013 00000028 0000002c 1 00 00000007
3 000002b3 0000002c 00000030 1 05 00000000
4 00108463 00000030 00000038 0 00 00000000
4 00208463 00000038 0000003c 0 00 00000000
4 00209463 0000003c 00000044 0 00 00000000
4 00109463 00000044 00000048 0 00 00000000
4 00114463 00000048 00000050 0 00 00000000
4 0020c463 00000050 00000054 0 00 00000000
4 0020d463 00000054 0000005c 0 00 00000000
4 00115463 0000005c 00000060 0 00 00000000
4 0020e463 00000060 00000068 0 00 00000000
4 00116463 00000068 0000006c 0 00 00000000
4 00117463 0000006c 00000074 0 00 00000000
4 0020f463 00000074 00000078 0 00 00000000
5 010005ef 00000078 00000088 1 0b 0000007c
5 00001617 00000088 0000008c 1 0c 00001088
5 0a100693 0000008c 00000090 1 0d 000000a1
5 01068767 00000090 000000b0 1 0e 00000094
5 ff1ff06f 000000b0 000000a0 1 00 000000b4
6 00112023 000000a0 000000a4 0 00 00000000
6 0000a183 000000a4 000000a8 0 00 00000000
6 000187b3 000000a8 000000ac 1 0f 12345000

/* verilog.f */
verilog/cpu_types_pkg.sv
verilog/cpu_ctrl_pkg.sv
verilog/control_unit.sv
verilog/imm_decode.sv
verilog/register_file.sv
verilog/alu.sv
verilog/pc_unit.sv
verilog/cpu.sv
testbench/cpu_asserts.sv
testbench/cpu_tb.sv

/* verilog/alu.sv */
/*
 * integer alu
 *   add/sub/compare on one shared adder
 *   shifts, logic ops, pass-through of b
 *   less and zero flags for branches
 */
module alu (
    input  cpu_ctrl_pkg::alu_op_e op,
    input  cpu_types_pkg::word_t  a,
    input  cpu_types_pkg::word_t  b,
    output cpu_types_pkg::word_t  result,
    output logic                  less,
    output logic                  zero
);
    import cpu_types_pkg::*;
    import cpu_ctrl_pkg::*;

    logic        sub;
    logic [32:0] sum;
    logic        less_s;
    logic        less_u;
    logic [4:0]  shamt;

    // compares run as a - b
    assign sub = op inside {ALU_SUB, ALU_SLT, ALU_SLTU};
    assign sum = {1'b0, a} + {1'b0, sub ? ~b : b} + 33'(sub);

    // no carry out of a - b means borrow
    assign less_u = !sum[32];
    // sign of a decides when signs differ, else sign of difference
    assign less_s = (a[31] != b[31]) ? a[31] : sum[31];
    assign less   = (op == ALU_SLTU) ? less_u : less_s;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD, ALU_SUB: result = sum[31:0];
            ALU_SLL:          result = a << shamt;
            ALU_SLT:          result = {31'b0, less_s};
            ALU_SLTU:         result = {31'b0, less_u};
            ALU_XOR:          result = a ^ b;
            ALU_SRL:          result = a >> shamt;
            ALU_SRA:          result = $signed(a) >>> shamt;
            ALU_OR:           result = a | b;
            ALU_AND:          result = a & b;
            ALU_PASS_B:       result = b;
            default:          result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* verilog/control_unit.sv */
/*
 * main decoder
 *   opcode/funct3/funct7 to ctrl_t bundle
 *   branch compare select and taken resolution
 */
module control_unit (
    input  cpu_types_pkg::word_t cmd,
    input  logic                 less,
    input  logic                 zero,
    output cpu_ctrl_pkg::ctrl_t  ctrl,
    output logic                 taken
);
    import cpu_ctrl_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;
    logic       cond;

    // shared op/op-imm mapping
    function automatic alu_op_e arith_op(input logic alt_bit, input logic [2:0] f3);
        case (f3)
            3'b000:  arith_op = alt_bit ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt_bit ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    endfunction

    assign opcode = opcode_e'(cmd[6:0]);
    assign funct3 = cmd[14:12];
    // funct7 bit 5 of the instruction
    assign alt    = cmd[30];

    always_comb begin
        // no-op bundle, also for unsupported opcodes
        ctrl = '{alu_op: ALU_ADD, a_src: A_RS1, b_src: B_RS2, imm_fmt: IMM_I,
                 wb_en: 1'b0, wb_link: 1'b0, jump: 1'b0, jalr: 1'b0,
                 is_branch: 1'b0, br_funct: funct3};
        case (opcode)
            OPC_OP: begin
                ctrl.alu_op = arith_op(alt, funct3);
                ctrl.wb_en  = 1'b1;
            end
            OPC_OP_IMM: begin
                // addi etc ignore bit 30, only shifts look at it
                ctrl.alu_op = arith_op(alt && (funct3 == F3_SR), funct3);
                ctrl.b_src  = B_IMM;
                ctrl.wb_en  = 1'b1;
            end
            OPC_LUI: begin
                ctrl.alu_op  = ALU_PASS_B;
                ctrl.b_src   = B_IMM;
                ctrl.imm_fmt = IMM_U;
                ctrl.wb_en   = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.a_src   = A_PC;
                ctrl.b_src   = B_IMM;
                ctrl.imm_fmt = IMM_U;
                ctrl.wb_en   = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                // alu idle, target comes from pc_unit
                ctrl.imm_fmt = (opcode == OPC_JAL) ? IMM_J : IMM_I;
                ctrl.wb_en   = 1'b1;
                ctrl.wb_link = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.jalr    = (opcode == OPC_JALR);
            end
            OPC_BRANCH: begin
                ctrl.imm_fmt   = IMM_B;
                ctrl.is_branch = 1'b1;
                // beq/bne by zero of sub, others by less
                if (!funct3[2])
                    ctrl.alu_op = ALU_SUB;
                else
                    ctrl.alu_op = funct3[1] ? ALU_SLTU : ALU_SLT;
            end
            default: ;
        endcase
    end

    // branch condition from alu flags
    always_comb begin
        case (ctrl.br_funct)
            F3_BEQ:           cond = zero;
            F3_BNE:           cond = !zero;
            F3_BLT, F3_BLTU:  cond = less;
            F3_BGE, F3_BGEU:  cond = !less;
            default:          cond = 1'b0;
        endcase
        taken = ctrl.is_branch && cond;
    end

endmodule

/* verilog/cpu.sv */
/*
 * single-cycle rv32i core top
 *   decoders, register file, alu, pc unit
 *   alu operand muxes and writeback select
 */
module cpu (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_types_pkg::word_t   cmd,
    output cpu_types_pkg::word_t   pc,
    output cpu_types_pkg::word_t   dnpc,
    output cpu_types_pkg::commit_t commit
);
    import cpu_types_pkg::*;
    import cpu_ctrl_pkg::*;

    // register indices from the instruction
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;

    ctrl_t ctrl;
    logic  taken;
    logic  less;
    logic  zero;

    word_t imm;
    word_t src1;
    word_t src2;
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    word_t link_addr;

    assign rs1_addr = cmd[19:15];
    assign rs2_addr = cmd[24:20];

    // decode, both sides read cmd in parallel
    control_unit cu0 (
        .cmd   (cmd),
        .less  (less),
        .zero  (zero),
        .ctrl  (ctrl),
        .taken (taken)
    );

    imm_decode imm0 (
        .cmd (cmd),
        .fmt (ctrl.imm_fmt),
        .imm (imm)
    );

    // commit bundle is also the write port
    register_file rf0 (
        .clk     (clk),
        .raddr_a (rs1_addr),
        .raddr_b (rs2_addr),
        .wr      (commit),
        .rdata_a (src1),
        .rdata_b (src2)
    );

    // alu operand select
    assign alu_a = (ctrl.a_src == A_PC)  ? pc  : src1;
    assign alu_b = (ctrl.b_src == B_IMM) ? imm : src2;

    alu alu0 (
        .op     (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .less   (less),
        .zero   (zero)
    );

    pc_unit pc0 (
        .clk   (clk),
        .rst   (rst),
        .imm   (imm),
        .rs1   (src1),
        .jump  (ctrl.jump),
        .jalr  (ctrl.jalr),
        .taken (taken),
        .pc    (pc),
        .dnpc  (dnpc)
    );

    // writeback, link address for jal/jalr
    assign link_addr   = pc + PC_STEP;
    // nothing retires during reset
    assign commit.en   = ctrl.wb_en && !rst;
    assign commit.rd   = cmd[11:7];
    assign commit.data = ctrl.wb_link ? link_addr : alu_result;

endmodule

/* verilog/cpu_ctrl_pkg.sv */
/*
 * control encodings for the rv32i core
 *   major opcodes, alu operations, immediate formats
 *   alu operand sources, branch funct3 codes
 *   ctrl_t bundle from the decoder
 */
package cpu_ctrl_pkg;

    // supported major opcodes only
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // {funct7[5], funct3} where it applies
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB    = 4'b1000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_SRA    = 4'b1101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        ALU_PASS_B = 4'b1111
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_fmt_e;

    typedef enum logic {A_RS1 = 1'b0, A_PC = 1'b1} a_src_e;
    typedef enum logic {B_RS2 = 1'b0, B_IMM = 1'b1} b_src_e;

    // funct3 of conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // funct3 of srl/sra, the only op-imm using funct7
    localparam logic [2:0] F3_SR   = 3'b101;

    typedef struct packed {
        alu_op_e    alu_op;
        a_src_e     a_src;
        b_src_e     b_src;
        imm_fmt_e   imm_fmt;
        logic       wb_en;
        logic       wb_link;   // rd gets pc + 4
        logic       jump;      // jal or jalr
        logic       jalr;      // target base is rs1
        logic       is_branch;
        logic [2:0] br_funct;
    } ctrl_t;

endpackage

/* verilog/cpu_types_pkg.sv */
/*
 * data-width types for the rv32i datapath
 *   word_t, reg_addr_t
 *   commit_t writeback bundle
 *   reset pc and sequential pc step
 */
package cpu_types_pkg;

    // data, pc and instruction words
    typedef logic [31:0] word_t;

    // x0..x31 index
    typedef logic [4:0] reg_addr_t;

    // pc after reset
    localparam word_t RESET_PC = 32'h0000_0000;

    // fall-through step, also the link offset
    localparam word_t PC_STEP = 32'd4;

    // one register write per retired instruction
    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        word_t     data;
    } commit_t;

endpackage

/* verilog/imm_decode.sv */
/*
 * immediate decoder
 *   i, s, b, u and j formats
 *   sign extension from instruction bit 31
 */
module imm_decode (
    input  cpu_types_pkg::word_t   cmd,
    input  cpu_ctrl_pkg::imm_fmt_e fmt,
    output cpu_types_pkg::word_t   imm
);
    import cpu_types_pkg::*;
    import cpu_ctrl_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // alu immediates, jalr offset
    assign imm_i = {{21{cmd[31]}}, cmd[30:20]};
    // split across rd field
    assign imm_s = {{21{cmd[31]}}, cmd[30:25], cmd[11:7]};
    // halfword offset, bit 11 sits at cmd[7]
    assign imm_b = {{20{cmd[31]}}, cmd[7], cmd[30:25], cmd[11:8], 1'b0};
    // upper 20 bits, low part zero
    assign imm_u = {cmd[31:12], 12'b0};
    // jal offset, scrambled order
    assign imm_j = {{12{cmd[31]}}, cmd[19:12], cmd[20], cmd[30:21], 1'b0};

    always_comb begin
        case (fmt)
            IMM_S:   imm = imm_s;
            IMM_B:   imm = imm_b;
            IMM_U:   imm = imm_u;
            IMM_J:   imm = imm_j;
            default: imm = imm_i;
        endcase
    end

endmodule

/* verilog/pc_unit.sv */
/*
 * program counter
 *   next-pc adder with base/offset select
 *   jalr target bit 0 clear, pc register
 */
module pc_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_types_pkg::word_t imm,
    input  cpu_types_pkg::word_t rs1,
    input  logic                 jump,
    input  logic                 jalr,
    input  logic                 taken,
    output cpu_types_pkg::word_t pc,
    output cpu_types_pkg::word_t dnpc
);
    import cpu_types_pkg::*;

    word_t base;
    word_t offset;
    word_t target;

    // rs1 only for jalr, pc otherwise
    assign base   = jalr ? rs1 : pc;
    // imm on any redirect, sequential step else
    assign offset = (jump || taken) ? imm : PC_STEP;
    assign target = base + offset;
    assign dnpc   = jalr ? {target[31:1], 1'b0} : target;

    always_ff @(posedge clk) begin
        if (rst)
            pc <= RESET_PC;
        else
            pc <= dnpc;
    end

endmodule

/* verilog/register_file.sv */
/*
 * integer register file x0..x31
 *   two async read ports
 *   one sync write port from the commit bundle
 */
module register_file (
    input  logic                      clk,
    input  cpu_types_pkg::reg_addr_t  raddr_a,
    input  cpu_types_pkg::reg_addr_t  raddr_b,
    input  cpu_types_pkg::commit_t    wr,
    output cpu_types_pkg::word_t      rdata_a,
    output cpu_types_pkg::word_t      rdata_b
);
    import cpu_types_pkg::*;

    word_t regs [32];

    // writes to x0 are dropped
    always_ff @(posedge clk) begin
        if (wr.en && (wr.rd != '0)) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // x0 reads as zero regardless of array content
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule
